/* src/cdc_fifo_defines.svh */
// Depth must be a power of two and every synchronizer chain needs at least two flip-flops
`ifndef CDC_FIFO_DEFINES_SVH
`define CDC_FIFO_DEFINES_SVH

// Payload bits carried in each beat
`define CDC_DATA_WIDTH 16

// Log2 of the number of storage words
// Pointers carry one extra bit to tell full from empty
`define CDC_LOG_DEPTH 3

// Number of storage words in the source domain
`define CDC_DEPTH (1 << `CDC_LOG_DEPTH)

// Flip-flops per synchronizer chain
// More stages give more settling time at the cost of latency
`define CDC_SYNC_STAGES 2

`endif

/* src/cdc_fifo_pkg.sv */
// Pointer helpers assume a pointer one bit wider than the storage address
`default_nettype none

`include "cdc_fifo_defines.svh"

package cdc_fifo_pkg;

  // One beat as it crosses the FIFO
  typedef struct packed {
    logic [`CDC_DATA_WIDTH-1:0] data;
    logic                       last;
  } cdc_beat_t;

  // Binary or Gray pointer with the wrap bit on top
  typedef logic [`CDC_LOG_DEPTH:0] cdc_ptr_t;

  // Reflected binary code of a pointer
  function automatic cdc_ptr_t bin_to_gray(input cdc_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Undo the Gray code from the top bit downwards
  function automatic cdc_ptr_t gray_to_bin(input cdc_ptr_t gray);
    cdc_ptr_t bin;
    bin = gray;
    for (int i = $bits(cdc_ptr_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

/* src/gray_ptr_counter.sv */
// Pointer wraps at twice the depth and clears only through the synchronous reset
`default_nettype none

module gray_ptr_counter import cdc_fifo_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic inc_i,
  output cdc_ptr_t  bin_o,
  output cdc_ptr_t  gray_o
);

  // Gray value is the stored state
  // so the crossing wires come straight off a flip-flop
  cdc_ptr_t gray_q;
  cdc_ptr_t gray_d;
  cdc_ptr_t bin;

  // Binary view for addressing and compares
  assign bin = gray_to_bin(gray_q);

  // Next position in Gray order
  assign gray_d = bin_to_gray(cdc_ptr_t'(bin + 1'b1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gray_q <= '0;
    end else if (inc_i) begin
      gray_q <= gray_d;
    end
  end

  assign bin_o  = bin;
  assign gray_o = gray_q;

  // Receiving side may sample mid-change
  // a single moving bit keeps that sample at the old or the new position
  gray_one_step_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $countones(gray_q ^ $past(gray_q)) <= 1
  ) else $error("gray pointer moved more than one bit in a cycle");

endmodule

`default_nettype wire

/* src/bit_sync.sv */
// Only for Gray-coded or quasi-static inputs since each bit settles on its own
`default_nettype none

`include "cdc_fifo_defines.svh"

module bit_sync #(
  parameter int WIDTH = 1
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic [WIDTH-1:0] async_i,
  output logic      [WIDTH-1:0] sync_o
);

  // Stage 0 faces the other domain
  // the last stage feeds the local logic
  logic [`CDC_SYNC_STAGES-1:0][WIDTH-1:0] stage_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage_q <= '0;
    end else begin
      // Shift every bit one stage deeper
      stage_q <= {stage_q[`CDC_SYNC_STAGES-2:0], async_i};
    end
  end

  // Oldest stage has had the most time to settle
  assign sync_o = stage_q[`CDC_SYNC_STAGES-1];

endmodule

`default_nettype wire

/* src/spill_register.sv */
// Holds up to two beats and its input ready only looks at its own state
`default_nettype none

module spill_register import cdc_fifo_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      valid_i,
  output logic           ready_o,
  input  wire cdc_beat_t beat_i,
  output logic           valid_o,
  input  wire logic      ready_i,
  output cdc_beat_t      beat_o
);

  // Number of beats held
  typedef enum logic [1:0] {
    spill_empty = 2'd0,
    spill_one   = 2'd1,
    spill_two   = 2'd2
  } spill_state_e;

  spill_state_e state_q;
  spill_state_e state_d;
  // Slot A is the head, slot B catches a beat while A is stuck
  cdc_beat_t    slot_a_q;
  cdc_beat_t    slot_b_q;
  logic         push;
  logic         pop;
  logic         load_a_in;
  logic         load_a_b;
  logic         load_b;

  // Room for one more unless both slots are taken
  assign ready_o = (state_q != spill_two);
  assign valid_o = (state_q != spill_empty);
  assign beat_o  = slot_a_q;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Input lands in A when A is free or drains this cycle
  assign load_a_in = push & ((state_q == spill_empty) | ((state_q == spill_one) & pop));
  // B moves up once A drains
  assign load_a_b  = pop & (state_q == spill_two);
  // Input parks in B when A stays
  assign load_b    = push & ~pop & (state_q == spill_one);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      spill_empty: begin
        if (push) begin
          state_d = spill_one;
        end
      end
      spill_one: begin
        if (push & ~pop) begin
          state_d = spill_two;
        end else if (~push & pop) begin
          state_d = spill_empty;
        end
      end
      spill_two: begin
        if (pop) begin
          state_d = spill_one;
        end
      end
      default: state_d = spill_empty;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= spill_empty;
    end else begin
      state_q <= state_d;
    end
  end

  // Beat slots
  always_ff @(posedge clk_i) begin
    if (load_a_in) begin
      slot_a_q <= beat_i;
    end else if (load_a_b) begin
      slot_a_q <= slot_b_q;
    end
    if (load_b) begin
      slot_b_q <= beat_i;
    end
  end

  // Offered beat stays put until the consumer takes it
  hold_while_stalled_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(beat_o)
  ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

/* src/cdc_fifo_src.sv */
// Source ready depends on a delayed read pointer so free space shows up a few cycles late
`default_nettype none

`include "cdc_fifo_defines.svh"

module cdc_fifo_src import cdc_fifo_pkg::*; (
  input  wire logic                        src_clk_i,
  input  wire logic                        rst_i,
  input  wire cdc_beat_t                   src_beat_i,
  input  wire logic                        src_valid_i,
  output logic                             src_ready_o,
  output cdc_beat_t [`CDC_DEPTH-1:0]       async_data_o,
  output cdc_ptr_t                         async_wptr_o,
  input  wire cdc_ptr_t                    async_rptr_i
);

  // Pointers that differ only in the wrap bit mean full
  localparam cdc_ptr_t full_xor = cdc_ptr_t'(`CDC_DEPTH);

  cdc_beat_t [`CDC_DEPTH-1:0] data_q;
  cdc_ptr_t                   wptr_bin;
  cdc_ptr_t                   rptr_gray;
  cdc_ptr_t                   rptr_bin;
  logic                       write;

  // Source handshake
  assign write = src_valid_i & src_ready_o;

  // Storage words
  // only the addressed word loads and the rest keep their contents
  always_ff @(posedge src_clk_i) begin
    if (write) begin
      data_q[wptr_bin[`CDC_LOG_DEPTH-1:0]] <= src_beat_i;
    end
  end

  // Destination reads the words directly
  // its pointer only passes a word after the write pointer has crossed
  assign async_data_o = data_q;

  // Write pointer steps once per accepted beat
  gray_ptr_counter u_wptr (
    .clk_i  (src_clk_i),
    .rst_i  (rst_i),
    .inc_i  (write),
    .bin_o  (wptr_bin),
    .gray_o (async_wptr_o)
  );

  // Read pointer from the destination domain
  bit_sync #(
    .WIDTH ($bits(cdc_ptr_t))
  ) u_rptr_sync (
    .clk_i   (src_clk_i),
    .rst_i   (rst_i),
    .async_i (async_rptr_i),
    .sync_o  (rptr_gray)
  );

  assign rptr_bin = gray_to_bin(rptr_gray);

  // Full when only the wrap bit differs
  assign src_ready_o = ((wptr_bin ^ rptr_bin) != full_xor);

  // Stale read pointer only ever undercounts free space
  // so the source never runs past a word that is still unread
  no_overrun_a: assert property (
    @(posedge src_clk_i) disable iff (rst_i)
    cdc_ptr_t'(wptr_bin - rptr_bin) <= cdc_ptr_t'(`CDC_DEPTH)
  ) else $error("source wrote into a word the destination has not read");

endmodule

`default_nettype wire

/* src/cdc_fifo_dst.sv */
// Destination sees new words a few cycles late and the spill register adds one more
`default_nettype none

`include "cdc_fifo_defines.svh"

module cdc_fifo_dst import cdc_fifo_pkg::*; (
  input  wire logic                        dst_clk_i,
  input  wire logic                        rst_i,
  output cdc_beat_t                        dst_beat_o,
  output logic                             dst_valid_o,
  input  wire logic                        dst_ready_i,
  input  wire cdc_beat_t [`CDC_DEPTH-1:0]  async_data_i,
  input  wire cdc_ptr_t                    async_wptr_i,
  output cdc_ptr_t                         async_rptr_o
);

  cdc_ptr_t  rptr_bin;
  cdc_ptr_t  wptr_gray;
  cdc_ptr_t  wptr_bin;
  cdc_beat_t rd_beat;
  logic      rd_valid;
  logic      rd_ready;
  logic      rd_take;

  // Write pointer from the source domain
  bit_sync #(
    .WIDTH ($bits(cdc_ptr_t))
  ) u_wptr_sync (
    .clk_i   (dst_clk_i),
    .rst_i   (rst_i),
    .async_i (async_wptr_i),
    .sync_o  (wptr_gray)
  );

  assign wptr_bin = gray_to_bin(wptr_gray);

  // Any difference means at least one unread word
  assign rd_valid = (wptr_bin != rptr_bin);

  // Word at the head of the FIFO
  // stable here because the source only writes words past the read pointer
  assign rd_beat = async_data_i[rptr_bin[`CDC_LOG_DEPTH-1:0]];

  // Word leaves storage when the spill register takes it
  assign rd_take = rd_valid & rd_ready;

  // Read pointer steps once per word handed on
  gray_ptr_counter u_rptr (
    .clk_i  (dst_clk_i),
    .rst_i  (rst_i),
    .inc_i  (rd_take),
    .bin_o  (rptr_bin),
    .gray_o (async_rptr_o)
  );

  // Output stage
  // cuts the path from dst_ready_i back into the pointer logic
  spill_register u_spill (
    .clk_i   (dst_clk_i),
    .rst_i   (rst_i),
    .valid_i (rd_valid),
    .ready_o (rd_ready),
    .beat_i  (rd_beat),
    .valid_o (dst_valid_o),
    .ready_i (dst_ready_i),
    .beat_o  (dst_beat_o)
  );

endmodule

`default_nettype wire

/* src/cdc_fifo_gray.sv */
// Both clocks must run during the shared reset, which each side samples synchronously
`default_nettype none

`include "cdc_fifo_defines.svh"

module cdc_fifo_gray import cdc_fifo_pkg::*; (
  input  wire logic      src_clk_i,
  input  wire logic      dst_clk_i,
  input  wire logic      rst_i,
  // Source port
  input  wire cdc_beat_t src_beat_i,
  input  wire logic      src_valid_i,
  output logic           src_ready_o,
  // Destination port
  output cdc_beat_t      dst_beat_o,
  output logic           dst_valid_o,
  input  wire logic      dst_ready_i
);

  // Nets that cross between the clock domains
  // storage words, Gray write pointer and Gray read pointer
  cdc_beat_t [`CDC_DEPTH-1:0] async_data;
  cdc_ptr_t                   async_wptr;
  cdc_ptr_t                   async_rptr;

  // Writes words and watches the returning read pointer
  cdc_fifo_src u_src (
    .src_clk_i    (src_clk_i),
    .rst_i        (rst_i),
    .src_beat_i   (src_beat_i),
    .src_valid_i  (src_valid_i),
    .src_ready_o  (src_ready_o),
    .async_data_o (async_data),
    .async_wptr_o (async_wptr),
    .async_rptr_i (async_rptr)
  );

  // Reads words and returns its read pointer
  cdc_fifo_dst u_dst (
    .dst_clk_i    (dst_clk_i),
    .rst_i        (rst_i),
    .dst_beat_o   (dst_beat_o),
    .dst_valid_o  (dst_valid_o),
    .dst_ready_i  (dst_ready_i),
    .async_data_i (async_data),
    .async_wptr_i (async_wptr),
    .async_rptr_o (async_rptr)
  );

endmodule

`default_nettype wire

/* testbench/cdc_fifo_checker.sv */
// Expects inputs to change away from rising edges and a FIFO of 8 storage words plus 2 spill slots
`default_nettype none

module cdc_fifo_checker import cdc_fifo_pkg::*; (
  input  wire logic      src_clk_i,
  input  wire logic      dst_clk_i,
  input  wire logic      rst_i,
  input  wire cdc_beat_t src_beat_i,
  input  wire logic      src_valid_i,
  input  wire logic      src_ready_i,
  input  wire cdc_beat_t dst_beat_i,
  input  wire logic      dst_valid_i,
  input  wire logic      dst_ready_i,
  output int             mismatch_count_o,
  output int             protocol_count_o,
  output int             pending_o,
  output int             received_o,
  output logic           full_seen_o
);

  localparam int QUEUE_SLOTS   = 64;
  // Storage depth alone, then storage plus both spill slots
  localparam int FILL_MIN      = 8;
  localparam int FILL_MAX      = 10;
  // Destination edges with ready low before the read pointer is surely settled
  localparam int SETTLED_STALL = 6;

  // Expected beats, written by the source edge and read by the destination edge
  cdc_beat_t expected_mem [0:QUEUE_SLOTS-1];
  int        push_count  = 0;
  int        pop_count   = 0;
  int        src_errors  = 0;
  int        dst_errors  = 0;
  int        mismatches  = 0;
  int        stall_run   = 0;
  logic      src_started = 1'b0;
  logic      dst_started = 1'b0;
  logic      stalled_q   = 1'b0;
  logic      full_seen   = 1'b0;
  cdc_beat_t held_beat;
  cdc_beat_t expected_beat;

  // Source domain
  always @(posedge src_clk_i) begin
    if (!rst_i) begin
      // First edge after reset still shows the reset state
      if (!src_started) begin
        src_started <= 1'b1;
        if (!src_ready_i) begin
          $display("CHECK FAILED @%0t: src_ready_o low right after reset", $time);
          src_errors++;
        end
      end
      if (src_valid_i && src_ready_i) begin
        expected_mem[push_count % QUEUE_SLOTS] <= src_beat_i;
        push_count <= push_count + 1;
      end
      // No reads during a long stall, so a low ready means the FIFO is really full
      if (!src_ready_i && stall_run >= SETTLED_STALL) begin
        full_seen <= 1'b1;
        if (push_count - pop_count < FILL_MIN || push_count - pop_count > FILL_MAX) begin
          $display("CHECK FAILED @%0t: ready fell with %0d beats held, expected %0d to %0d",
                   $time, push_count - pop_count, FILL_MIN, FILL_MAX);
          src_errors++;
        end
      end
    end
  end

  // Destination domain
  always @(posedge dst_clk_i) begin
    if (!rst_i) begin
      if (!dst_started) begin
        dst_started <= 1'b1;
        if (dst_valid_i) begin
          $display("CHECK FAILED @%0t: dst_valid_o high right after reset", $time);
          dst_errors++;
        end
      end
      // Stalled beat must still be offered unchanged
      if (stalled_q && !(dst_valid_i && dst_beat_i === held_beat)) begin
        $display("CHECK FAILED @%0t: dst beat changed or vanished while stalled", $time);
        dst_errors++;
      end
      if (dst_valid_i && push_count == pop_count) begin
        $display("CHECK FAILED @%0t: dst_valid_o high with no beat outstanding", $time);
        dst_errors++;
      end else if (dst_valid_i && dst_ready_i) begin
        expected_beat = expected_mem[pop_count % QUEUE_SLOTS];
        if (dst_beat_i.data !== expected_beat.data || dst_beat_i.last !== expected_beat.last) begin
          $display("CHECK FAILED @%0t: beat %0d got data %h last %b, expected data %h last %b",
                   $time, pop_count, dst_beat_i.data, dst_beat_i.last,
                   expected_beat.data, expected_beat.last);
          mismatches++;
        end
        pop_count <= pop_count + 1;
      end
      stalled_q <= dst_valid_i && !dst_ready_i;
      held_beat <= dst_beat_i;
      stall_run <= dst_ready_i ? 0 : stall_run + 1;
    end
  end

  assign mismatch_count_o = mismatches;
  assign protocol_count_o = src_errors + dst_errors;
  assign pending_o        = push_count - pop_count;
  assign received_o       = pop_count;
  assign full_seen_o      = full_seen;

endmodule

`default_nettype wire

/* testbench/tb_cdc_fifo_gray.sv */
// Must run from the project root for the golden file path and keeps the clocks at 8 and 13 units
`default_nettype none

module tb_cdc_fifo_gray import cdc_fifo_pkg::*; ();

  localparam int          SRC_PERIOD     = 8;
  localparam int          DST_HIGH       = 6;
  localparam int          DST_LOW        = 7;
  localparam int          DST_PERIOD     = DST_HIGH + DST_LOW;
  localparam int          RESET_CYCLES   = 16;
  localparam int          BEAT_COUNT     = 16;
  localparam int          RAND_STALL_MAX = 2;
  localparam int          SETTLE_CYCLES  = 20;
  localparam logic [31:0] SEED           = 32'hde54_eacb;

  logic        src_clk   = 1'b0;
  logic        dst_clk   = 1'b0;
  logic        rst       = 1'b1;
  cdc_beat_t   src_beat  = '0;
  logic        src_valid = 1'b0;
  logic        src_ready;
  cdc_beat_t   dst_beat;
  logic        dst_valid;
  logic        dst_ready = 1'b0;

  // Golden word holds data[35:20] last[19:16] gap[15:8] stall[7:0]
  logic [35:0] golden_mem [0:BEAT_COUNT-1];
  longint      watchdog_time;
  int          beat_total;
  int          max_gap;
  int          max_stall;
  int          end_errors;
  int          mismatches;
  int          protocol_errors;
  int          pending;
  int          received;
  logic        full_seen;

  always #(SRC_PERIOD / 2) src_clk = ~src_clk;

  // Uneven halves give a 13 unit period
  always begin
    #DST_HIGH dst_clk = 1'b1;
    #DST_LOW  dst_clk = 1'b0;
  end

  cdc_fifo_gray u_cdc_fifo_gray (
    .src_clk_i   (src_clk),
    .dst_clk_i   (dst_clk),
    .rst_i       (rst),
    .src_beat_i  (src_beat),
    .src_valid_i (src_valid),
    .src_ready_o (src_ready),
    .dst_beat_o  (dst_beat),
    .dst_valid_o (dst_valid),
    .dst_ready_i (dst_ready)
  );

  cdc_fifo_checker u_checker (
    .src_clk_i        (src_clk),
    .dst_clk_i        (dst_clk),
    .rst_i            (rst),
    .src_beat_i       (src_beat),
    .src_valid_i      (src_valid),
    .src_ready_i      (src_ready),
    .dst_beat_i       (dst_beat),
    .dst_valid_i      (dst_valid),
    .dst_ready_i      (dst_ready),
    .mismatch_count_o (mismatches),
    .protocol_count_o (protocol_errors),
    .pending_o        (pending),
    .received_o       (received),
    .full_seen_o      (full_seen)
  );

  // Idle for the gap and then offer the beat until it is taken
  task automatic send_beats();
    logic [35:0] word;
    for (int i = 0; i < beat_total; i++) begin
      word = golden_mem[i];
      if (word[15:8] != 0) begin
        src_valid = 1'b0;
        repeat (word[15:8]) @(negedge src_clk);
      end
      src_valid     = 1'b1;
      src_beat.data = word[35:20];
      src_beat.last = word[16];
      // Ready only moves on rising edges
      while (!src_ready) @(negedge src_clk);
      @(negedge src_clk);
    end
    src_valid = 1'b0;
  endtask

  // Hold ready low for the stall plus a random extra and then wait for a beat
  task automatic take_beats();
    int stall;
    for (int i = 0; i < beat_total; i++) begin
      stall     = golden_mem[i][7:0] + ($urandom % (RAND_STALL_MAX + 1));
      dst_ready = 1'b0;
      repeat (stall) @(negedge dst_clk);
      dst_ready = 1'b1;
      while (!dst_valid) @(negedge dst_clk);
      @(negedge dst_clk);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    $readmemh("testbench/cdc_fifo_golden.txt", golden_mem);
    // Count words up to the first unloaded one
    beat_total = 0;
    max_gap    = 0;
    max_stall  = 0;
    end_errors = 0;
    while (beat_total < BEAT_COUNT && !$isunknown(golden_mem[beat_total])) begin
      if (golden_mem[beat_total][15:8] > max_gap) begin
        max_gap = golden_mem[beat_total][15:8];
      end
      if (golden_mem[beat_total][7:0] > max_stall) begin
        max_stall = golden_mem[beat_total][7:0];
      end
      beat_total++;
    end
    // Each beat may wait out its gap, its stall and the crossing latency
    watchdog_time = longint'(BEAT_COUNT) * (max_gap + max_stall + RAND_STALL_MAX + SETTLE_CYCLES)
                    * DST_PERIOD + RESET_CYCLES * SRC_PERIOD;
    fork
      begin
        #(watchdog_time);
        $display("Run timed out after %0d time units before all beats arrived", watchdog_time);
        $display("sim failed");
        $finish;
      end
    join_none
    repeat (RESET_CYCLES) @(posedge src_clk);
    @(negedge src_clk);
    rst = 1'b0;
    fork
      send_beats();
      begin
        @(negedge dst_clk);
        take_beats();
      end
    join
    // Give the checker the last edges
    repeat (4) @(posedge dst_clk);
    if (beat_total != BEAT_COUNT) begin
      $display("Golden file holds %0d beats instead of %0d", beat_total, BEAT_COUNT);
      end_errors++;
    end
    if (pending != 0) begin
      $display("CHECK FAILED @%0t: %0d beats accepted but never delivered", $time, pending);
      end_errors++;
    end
    if (received != BEAT_COUNT) begin
      $display("CHECK FAILED @%0t: %0d beats delivered, expected %0d", $time, received, BEAT_COUNT);
      end_errors++;
    end
    if (!full_seen) begin
      $display("The long stall never filled the FIFO, so the full limit went unchecked");
      end_errors++;
    end
    $display("Errors: %0d mismatch, %0d protocol, %0d end of run",
             mismatches, protocol_errors, end_errors);
    if (mismatches + protocol_errors + end_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/cdc_fifo_golden.txt */
// One hex word per beat: data (4 digits), last (1), source gap (2), destination stall (2)
// Gap is idle source cycles before the beat, stall is destination cycles with ready low
123400000
abcd10201
000100003
5aa5001c8
ffff00000
800010000
0f0f00000
c3c300000
7e7e00002
135710000
246800000
9abc00000
def000001
432110000
000000504
beef10300

/* project.f */
+incdir+src
src/cdc_fifo_pkg.sv
src/gray_ptr_counter.sv
src/bit_sync.sv
src/spill_register.sv
src/cdc_fifo_src.sv
src/cdc_fifo_dst.sv
src/cdc_fifo_gray.sv
testbench/cdc_fifo_checker.sv
testbench/tb_cdc_fifo_gray.sv

/* Bender.yml */
package:
  name: cdc_fifo_gray

sources:
  - include_dirs:
      - src
    files:
      - src/cdc_fifo_pkg.sv
      - src/gray_ptr_counter.sv
      - src/bit_sync.sv
      - src/spill_register.sv
      - src/cdc_fifo_src.sv
      - src/cdc_fifo_dst.sv
      - src/cdc_fifo_gray.sv
  - target: test
    files:
      - testbench/cdc_fifo_checker.sv
      - testbench/tb_cdc_fifo_gray.sv
